//--- design/uart_pkg.sv
//////////////////////////////////////////////////////////////////////
// UART FIFO link package
// Widths, depths and baud divisor shared by the buffered serial link,
// with the vector types and the serializer and deserializer states
//////////////////////////////////////////////////////////////////////

package uart_pkg;

	// Byte and FIFO geometry
	localparam int DATA_W       = 8;
	localparam int FIFO_LGLEN   = 4;
	localparam int FIFO_DEPTH   = 1 << FIFO_LGLEN;

	// Fixed baud divisor, clocks per serial bit
	localparam int CLKS_PER_BIT = 16;

	typedef logic [DATA_W-1:0]                 byte_t;
	// Fill count and pointers, extra bit tells full from empty
	typedef logic [FIFO_LGLEN:0]               fill_t;
	typedef logic [$clog2(CLKS_PER_BIT)-1:0]   baud_cnt_t;
	typedef logic [$clog2(DATA_W)-1:0]         bit_cnt_t;

	// Serializer states
	typedef enum logic [1:0] {TX_IDLE, TX_START, TX_DATA, TX_STOP} tx_state_t;

	// Deserializer states
	typedef enum logic [1:0] {RX_IDLE, RX_START, RX_DATA, RX_STOP} rx_state_t;

endpackage

//--- design/fifo_if.sv
//////////////////////////////////////////////////////////////////////
// FIFO bus
// Write and read sides of one byte FIFO, with writer, reader and
// store views
//////////////////////////////////////////////////////////////////////
`timescale 1ns/1ps

interface fifo_if;
	import uart_pkg::*;

	// Write side
	logic  wr;
	byte_t wr_data;
	logic  full;
	fill_t fill;

	// Read side, head byte shown while not empty
	logic  rd;
	byte_t rd_data;
	logic  empty;

	// Producer of bytes
	modport writer (output wr, output wr_data, input full);

	// Consumer of bytes
	modport reader (output rd, input rd_data, input empty);

	// The FIFO itself
	modport store (
		input  wr,
		input  wr_data,
		input  rd,
		output full,
		output fill,
		output rd_data,
		output empty
	);

endinterface

//--- design/sfifo.sv
//////////////////////////////////////////////////////////////////////
// Synchronous byte FIFO
// First-word-fall-through store with registered fill count and
// registered full and empty flags. Pointers carry a wrap bit
//////////////////////////////////////////////////////////////////////
`timescale 1ns/1ps

module sfifo (
	input  logic   i_clk,
	input  logic   i_reset,
	fifo_if.store  bus
);
	import uart_pkg::*;

	// Storage, no reset needed on payload
	byte_t mem [FIFO_DEPTH];

	// Pointers with extra wrap bit
	fill_t wr_addr;
	fill_t rd_addr;

	// Registered status
	fill_t r_fill;
	logic  r_full;
	logic  r_empty;

	// Accepted strobes
	logic  w_wr;
	logic  w_rd;

	assign w_wr = bus.wr && !r_full;
	assign w_rd = bus.rd && !r_empty;

	//////////////////////////////////////////////////////////////////////
	// Fill count and flags
	//////////////////////////////////////////////////////////////////////

	// Fill count, resync from pointers when idle or both
	always_ff @(posedge i_clk)
	begin
		if (i_reset)
			r_fill <= '0;
		else
		begin
			case ({w_wr, w_rd})
			2'b01:   r_fill <= r_fill - 1'b1;
			2'b10:   r_fill <= r_fill + 1'b1;
			default: r_fill <= wr_addr - rd_addr;
			endcase
		end
	end

	// Full flag
	always_ff @(posedge i_clk)
	begin
		if (i_reset)
			r_full <= 1'b0;
		else
		begin
			case ({w_wr, w_rd})
			// Any read frees a slot
			2'b01:   r_full <= 1'b0;
			// Last free slot taken
			2'b10:   r_full <= (r_fill == fill_t'(FIFO_DEPTH - 1));
			default: r_full <= (r_fill == fill_t'(FIFO_DEPTH));
			endcase
		end
	end

	// Empty flag
	always_ff @(posedge i_clk)
	begin
		if (i_reset)
			r_empty <= 1'b1;
		else
		begin
			case ({w_wr, w_rd})
			// Last byte leaving
			2'b01:   r_empty <= (r_fill <= fill_t'(1));
			2'b10:   r_empty <= 1'b0;
			default: r_empty <= r_empty;
			endcase
		end
	end

	//////////////////////////////////////////////////////////////////////
	// Pointers and memory
	//////////////////////////////////////////////////////////////////////

	// Write pointer
	always_ff @(posedge i_clk)
	begin
		if (i_reset)
			wr_addr <= '0;
		else if (w_wr)
			wr_addr <= wr_addr + 1'b1;
	end

	// Read pointer
	always_ff @(posedge i_clk)
	begin
		if (i_reset)
			rd_addr <= '0;
		else if (w_rd)
			rd_addr <= rd_addr + 1'b1;
	end

	// Memory write, low pointer bits only
	always_ff @(posedge i_clk)
	begin
		if (w_wr)
			mem[wr_addr[FIFO_LGLEN-1:0]] <= bus.wr_data;
	end

	// Head byte, combinational read
	assign bus.rd_data = mem[rd_addr[FIFO_LGLEN-1:0]];

	// Status out
	assign bus.fill  = r_fill;
	assign bus.full  = r_full;
	assign bus.empty = r_empty;

endmodule

//--- design/uart_tx.sv
//////////////////////////////////////////////////////////////////////
// UART serializer
// Pops bytes from the transmit FIFO and shifts them out as 8N1
// frames, LSB first, with a registered line output idling high
//////////////////////////////////////////////////////////////////////
`timescale 1ns/1ps

module uart_tx (
	input  logic   i_clk,
	input  logic   i_reset,
	fifo_if.reader bus,
	output logic   o_uart_tx
);
	import uart_pkg::*;

	tx_state_t state;
	baud_cnt_t baud_cnt;
	bit_cnt_t  bit_cnt;
	byte_t     shift;
	logic      baud_end;
	logic      pop;

	// Last clock of the current bit
	assign baud_end = (baud_cnt == baud_cnt_t'(CLKS_PER_BIT - 1));

	// Pop when idle, or at end of stop bit to chain frames
	assign pop = !bus.empty
		&& ((state == TX_IDLE) || ((state == TX_STOP) && baud_end));
	assign bus.rd = pop;

	//////////////////////////////////////////////////////////////////////
	// Frame FSM
	//////////////////////////////////////////////////////////////////////
	always_ff @(posedge i_clk)
	begin
		if (i_reset)
		begin
			state     <= TX_IDLE;
			baud_cnt  <= '0;
			bit_cnt   <= '0;
			o_uart_tx <= 1'b1;
		end
		else
		begin
			baud_cnt <= baud_end ? '0 : baud_cnt + 1'b1;
			case (state)
			TX_IDLE:
			begin
				baud_cnt <= '0;
				// Start bit goes out next cycle
				if (pop)
				begin
					state     <= TX_START;
					o_uart_tx <= 1'b0;
				end
			end
			TX_START:
			begin
				if (baud_end)
				begin
					state     <= TX_DATA;
					bit_cnt   <= '0;
					o_uart_tx <= shift[0];
				end
			end
			TX_DATA:
			begin
				if (baud_end)
				begin
					// Eight bits done, drive stop
					if (bit_cnt == bit_cnt_t'(DATA_W - 1))
					begin
						state     <= TX_STOP;
						o_uart_tx <= 1'b1;
					end
					else
					begin
						bit_cnt   <= bit_cnt + 1'b1;
						o_uart_tx <= shift[0];
					end
				end
			end
			default:
			begin
				// Stop bit, back to back frames if queued
				if (baud_end)
				begin
					if (pop)
					begin
						state     <= TX_START;
						o_uart_tx <= 1'b0;
					end
					else
						state <= TX_IDLE;
				end
			end
			endcase
		end
	end

	// Shift register, loaded on pop, next bit at shift[0]
	always_ff @(posedge i_clk)
	begin
		if (pop)
			shift <= bus.rd_data;
		else if (baud_end && ((state == TX_START) || (state == TX_DATA)))
			shift <= {1'b0, shift[DATA_W-1:1]};
	end

endmodule

//--- design/uart_rx.sv
//////////////////////////////////////////////////////////////////////
// UART deserializer
// Synchronizes the line, finds the start edge, samples each bit at
// mid-bit and pushes good bytes into the receive FIFO. Flags framing
// errors and receive overflow
//////////////////////////////////////////////////////////////////////
`timescale 1ns/1ps

module uart_rx (
	input  logic   i_clk,
	input  logic   i_reset,
	input  logic   i_uart_rx,
	fifo_if.writer bus,
	output logic   o_rx_overflow,
	output logic   o_frame_err
);
	import uart_pkg::*;

	rx_state_t state;
	baud_cnt_t baud_cnt;
	bit_cnt_t  bit_cnt;
	byte_t     shift;

	// Two flop synchronizer, plus one stage for edge detect
	logic rx_meta;
	logic rx_line;
	logic rx_prev;

	logic start_edge;
	logic half_end;
	logic bit_end;
	logic stop_sample;

	always_ff @(posedge i_clk)
	begin
		if (i_reset)
		begin
			rx_meta <= 1'b1;
			rx_line <= 1'b1;
			rx_prev <= 1'b1;
		end
		else
		begin
			rx_meta <= i_uart_rx;
			rx_line <= rx_meta;
			rx_prev <= rx_line;
		end
	end

	assign start_edge  = rx_prev && !rx_line;
	// Mid start bit, then full bit periods
	assign half_end    = (baud_cnt == baud_cnt_t'(CLKS_PER_BIT / 2 - 1));
	assign bit_end     = (baud_cnt == baud_cnt_t'(CLKS_PER_BIT - 1));
	assign stop_sample = (state == RX_STOP) && bit_end;

	//////////////////////////////////////////////////////////////////////
	// Frame FSM
	//////////////////////////////////////////////////////////////////////
	always_ff @(posedge i_clk)
	begin
		if (i_reset)
		begin
			state    <= RX_IDLE;
			baud_cnt <= '0;
			bit_cnt  <= '0;
		end
		else
		begin
			baud_cnt <= baud_cnt + 1'b1;
			case (state)
			RX_IDLE:
			begin
				baud_cnt <= '0;
				if (start_edge)
					state <= RX_START;
			end
			RX_START:
			begin
				// Recheck at half a bit, glitches go back to idle
				if (half_end)
				begin
					baud_cnt <= '0;
					bit_cnt  <= '0;
					state    <= rx_line ? RX_IDLE : RX_DATA;
				end
			end
			RX_DATA:
			begin
				if (bit_end)
				begin
					baud_cnt <= '0;
					if (bit_cnt == bit_cnt_t'(DATA_W - 1))
						state <= RX_STOP;
					else
						bit_cnt <= bit_cnt + 1'b1;
				end
			end
			default:
			begin
				// Mid stop bit, wait for next start edge
				if (stop_sample)
					state <= RX_IDLE;
			end
			endcase
		end
	end

	// Data bits arrive LSB first, shift in at the top
	always_ff @(posedge i_clk)
	begin
		if ((state == RX_DATA) && bit_end)
			shift <= {rx_line, shift[DATA_W-1:1]};
	end

	// Push only good frames with room in the FIFO
	assign bus.wr      = stop_sample && rx_line && !bus.full;
	assign bus.wr_data = shift;

	// Low stop bit, byte dropped
	assign o_frame_err = stop_sample && !rx_line;

	// Sticky until reset
	always_ff @(posedge i_clk)
	begin
		if (i_reset)
			o_rx_overflow <= 1'b0;
		else if (stop_sample && rx_line && bus.full)
			o_rx_overflow <= 1'b1;
	end

endmodule

//--- design/uart_fifo_top.sv
//////////////////////////////////////////////////////////////////////
// Buffered UART link
// Transmit FIFO ahead of the serializer, receive FIFO behind the
// deserializer, host side on plain strobe and level ports
//////////////////////////////////////////////////////////////////////
`timescale 1ns/1ps

module uart_fifo_top (
	input  logic            i_clk,
	input  logic            i_reset,

	// Host transmit side
	input  logic            i_tx_wr,
	input  uart_pkg::byte_t i_tx_data,
	output logic            o_tx_full,
	output uart_pkg::fill_t o_tx_fill,

	// Host receive side
	input  logic            i_rx_rd,
	output uart_pkg::byte_t o_rx_data,
	output logic            o_rx_empty,
	output uart_pkg::fill_t o_rx_fill,

	// Status
	output logic            o_rx_overflow,
	output logic            o_frame_err,

	// Serial line
	output logic            o_uart_tx,
	input  logic            i_uart_rx
);

	fifo_if tx_fifo_bus ();
	fifo_if rx_fifo_bus ();

	//////////////////////////////////////////////////////////////////////
	// Transmit path
	//////////////////////////////////////////////////////////////////////

	// Host is the writer
	assign tx_fifo_bus.wr      = i_tx_wr;
	assign tx_fifo_bus.wr_data = i_tx_data;
	assign o_tx_full           = tx_fifo_bus.full;
	assign o_tx_fill           = tx_fifo_bus.fill;

	sfifo u_tx_fifo (
		.i_clk   (i_clk),
		.i_reset (i_reset),
		.bus     (tx_fifo_bus.store)
	);

	// Serializer drains the FIFO
	uart_tx u_uart_tx (
		.i_clk     (i_clk),
		.i_reset   (i_reset),
		.bus       (tx_fifo_bus.reader),
		.o_uart_tx (o_uart_tx)
	);

	//////////////////////////////////////////////////////////////////////
	// Receive path
	//////////////////////////////////////////////////////////////////////

	uart_rx u_uart_rx (
		.i_clk         (i_clk),
		.i_reset       (i_reset),
		.i_uart_rx     (i_uart_rx),
		.bus           (rx_fifo_bus.writer),
		.o_rx_overflow (o_rx_overflow),
		.o_frame_err   (o_frame_err)
	);

	sfifo u_rx_fifo (
		.i_clk   (i_clk),
		.i_reset (i_reset),
		.bus     (rx_fifo_bus.store)
	);

	// Host is the reader, head byte valid while not empty
	assign rx_fifo_bus.rd = i_rx_rd;
	assign o_rx_data      = rx_fifo_bus.rd_data;
	assign o_rx_empty     = rx_fifo_bus.empty;
	assign o_rx_fill      = rx_fifo_bus.fill;

endmodule

//--- testbench/tb_uart_fifo.sv
//////////////////////////////////////////////////////////////////////
// Buffered UART link testbench
// Loops the serial line back, keeps a queue model of the bytes in
// flight and checks every host read against it. Also covers transmit
// back-pressure, receive overflow and injected framing errors
//////////////////////////////////////////////////////////////////////
`timescale 1ns/1ps

module tb_uart_fifo;
	import uart_pkg::*;

	// Wait limits in clock cycles
	localparam int FRAME_CLKS = 10 * CLKS_PER_BIT;
	localparam int RX_WAIT    = 3 * FRAME_CLKS;
	localparam int ROOM_WAIT  = 2 * FRAME_CLKS;
	localparam int IDLE_WAIT  = 2 * FIFO_DEPTH * FRAME_CLKS;
	// Longer than any high run inside a frame
	localparam int QUIET_CLKS = 11 * CLKS_PER_BIT;

	logic  clk;
	logic  reset;
	logic  tx_wr;
	byte_t tx_data;
	logic  tx_full;
	fill_t tx_fill;
	logic  rx_rd;
	byte_t rx_data;
	logic  rx_empty;
	fill_t rx_fill;
	logic  rx_overflow;
	logic  frame_err;
	logic  uart_tx;
	logic  uart_rx;

	// Line source select, loopback or hand-built frames
	logic  loopback;
	logic  inj_line;

	// Bytes expected at the host read side, oldest first
	byte_t model_q[$];

	int    checks     = 0;
	int    errors     = 0;
	int    timeouts   = 0;
	int    frame_errs = 0;

	assign uart_rx = loopback ? uart_tx : inj_line;

	uart_fifo_top i_dut (
		.i_clk         (clk),
		.i_reset       (reset),
		.i_tx_wr       (tx_wr),
		.i_tx_data     (tx_data),
		.o_tx_full     (tx_full),
		.o_tx_fill     (tx_fill),
		.i_rx_rd       (rx_rd),
		.o_rx_data     (rx_data),
		.o_rx_empty    (rx_empty),
		.o_rx_fill     (rx_fill),
		.o_rx_overflow (rx_overflow),
		.o_frame_err   (frame_err),
		.o_uart_tx     (uart_tx),
		.i_uart_rx     (uart_rx)
	);

	// 10 ns clock
	initial
	begin
		clk = 1'b0;
		forever #5 clk = ~clk;
	end

	//////////////////////////////////////////////////////////////////////
	// Reference model and checks
	//////////////////////////////////////////////////////////////////////

	// Next byte the link should deliver
	function automatic byte_t expected_next();
		byte_t b;
		b = model_q.pop_front();
		return b;
	endfunction

	task automatic check_value(input string name, input logic [31:0] got,
		input logic [31:0] exp);
		checks++;
		assert (got === exp)
		else
		begin
			errors++;
			$display("FAIL %s: got 0x%0h, expected 0x%0h", name, got, exp);
		end
	endtask

	task automatic report_timeout(input string what, input int limit);
		timeouts++;
		$display("ERROR: no %s within %0d clock cycles", what, limit);
	endtask

	// Sampled before the edge, all DUT state moves after it
	always @(posedge clk)
	begin
		if (!reset)
		begin
			// Accepted host write joins the model
			if (tx_wr && !tx_full)
				model_q.push_back(tx_data);
			if (frame_err)
				frame_errs++;
			// Accepted host read, head byte against the model
			if (rx_rd && !rx_empty)
			begin
				checks++;
				assert (model_q.size() != 0)
				else
				begin
					errors++;
					$display("ERROR: host read a byte while none was expected");
				end
				if (model_q.size() != 0)
					check_value("o_rx_data", 32'(rx_data), 32'(expected_next()));
			end
		end
	end

	//////////////////////////////////////////////////////////////////////
	// Bounded waits and host tasks, all on the falling edge
	//////////////////////////////////////////////////////////////////////

	task automatic wait_rx_data(output logic ok);
		int n;
		n = 0;
		while (rx_empty && n < RX_WAIT)
		begin
			@(negedge clk);
			n++;
		end
		ok = !rx_empty;
		if (!ok)
			report_timeout("received byte", RX_WAIT);
	endtask

	task automatic wait_tx_room(output logic ok);
		int n;
		n = 0;
		while (tx_full && n < ROOM_WAIT)
		begin
			@(negedge clk);
			n++;
		end
		ok = !tx_full;
		if (!ok)
			report_timeout("free transmit slot", ROOM_WAIT);
	endtask

	// Transmit FIFO empty and line high for longer than a frame
	task automatic wait_link_idle();
		int n;
		int quiet;
		n = 0;
		quiet = 0;
		while (!(tx_fill == '0 && quiet >= QUIET_CLKS) && n < IDLE_WAIT)
		begin
			@(negedge clk);
			n++;
			quiet = uart_rx ? quiet + 1 : 0;
		end
		if (!(tx_fill == '0 && quiet >= QUIET_CLKS))
			report_timeout("idle serial line", IDLE_WAIT);
	endtask

	task automatic write_byte(input byte_t data);
		logic ok;
		wait_tx_room(ok);
		if (ok)
		begin
			tx_wr   = 1'b1;
			tx_data = data;
			@(negedge clk);
			tx_wr   = 1'b0;
		end
	endtask

	task automatic read_byte();
		logic ok;
		wait_rx_data(ok);
		if (ok)
		begin
			rx_rd = 1'b1;
			@(negedge clk);
			rx_rd = 1'b0;
		end
	endtask

	// Hand-built 8N1 frame on the injected line, LSB first
	task automatic send_frame(input byte_t data, input logic stop_bit);
		logic [9:0] frame;
		frame = {stop_bit, data, 1'b0};
		for (int i = 0; i < 10; i++)
		begin
			inj_line = frame[i];
			repeat (CLKS_PER_BIT) @(negedge clk);
		end
		inj_line = 1'b1;
		// Good frames only reach the receive FIFO
		if (stop_bit)
			model_q.push_back(data);
	endtask

	//////////////////////////////////////////////////////////////////////
	// Test sequence
	//////////////////////////////////////////////////////////////////////
	initial
	begin
		logic  ok;
		fill_t prev_fill;
		fill_t fill_before;
		int    step;
		int    accepted;
		int    n;

		void'($urandom(32'h5162bf56));
		reset    = 1'b1;
		tx_wr    = 1'b0;
		tx_data  = '0;
		rx_rd    = 1'b0;
		loopback = 1'b1;
		inj_line = 1'b1;
		repeat (5) @(negedge clk);
		reset = 1'b0;
		@(negedge clk);

		// Reset state
		check_value("o_uart_tx", 32'(uart_tx), 1);
		check_value("o_rx_empty", 32'(rx_empty), 1);
		check_value("o_tx_full", 32'(tx_full), 0);
		check_value("o_rx_overflow", 32'(rx_overflow), 0);
		check_value("o_tx_fill", 32'(tx_fill), 0);
		check_value("o_rx_fill", 32'(rx_fill), 0);

		// Single byte through the loop
		write_byte(byte_t'($urandom()));
		read_byte();
		check_value("o_rx_empty", 32'(rx_empty), 1);
		check_value("o_rx_fill", 32'(rx_fill), 0);

		// Burst, fill climbs by at most one per write
		prev_fill = tx_fill;
		for (int i = 0; i < FIFO_DEPTH; i++)
		begin
			write_byte(byte_t'($urandom()));
			step = int'(tx_fill) - int'(prev_fill);
			checks++;
			assert (step == 0 || step == 1)
			else
			begin
				errors++;
				$display("FAIL o_tx_fill: stepped from 0x%0h to 0x%0h", prev_fill, tx_fill);
			end
			prev_fill = tx_fill;
		end
		// Serializer took the first byte at once
		check_value("o_tx_fill", 32'(tx_fill), FIFO_DEPTH - 1);
		repeat (FIFO_DEPTH) read_byte();
		check_value("bytes left in model", model_q.size(), 0);

		// Back-pressure with the line disconnected
		loopback = 1'b0;
		accepted = 0;
		for (int i = 0; i < FIFO_DEPTH + 4; i++)
		begin
			if (!tx_full)
				accepted++;
			tx_wr   = 1'b1;
			tx_data = byte_t'($urandom());
			@(negedge clk);
		end
		tx_wr = 1'b0;
		check_value("o_tx_full", 32'(tx_full), 1);
		check_value("o_tx_fill", 32'(tx_fill), FIFO_DEPTH);
		// One slot freed by the first pop
		check_value("accepted writes", accepted, FIFO_DEPTH + 1);
		check_value("bytes in model", model_q.size(), FIFO_DEPTH + 1);
		// Second pop starts the next frame, reconnect there
		wait_tx_room(ok);
		loopback = 1'b1;
		// First frame went out on the disconnected line
		void'(model_q.pop_front());
		n = model_q.size();
		repeat (n) read_byte();
		check_value("bytes left in model", model_q.size(), 0);

		// Receive overflow, no reads until the line is quiet
		for (int i = 0; i < FIFO_DEPTH + 2; i++)
			write_byte(byte_t'($urandom()));
		wait_link_idle();
		check_value("o_rx_fill", 32'(rx_fill), FIFO_DEPTH);
		check_value("o_rx_overflow", 32'(rx_overflow), 1);
		repeat (FIFO_DEPTH) read_byte();
		// Last two frames met a full receive FIFO
		check_value("bytes left in model", model_q.size(), 2);
		model_q.delete();
		check_value("o_rx_empty", 32'(rx_empty), 1);

		// Framing error, then a good frame
		loopback = 1'b0;
		fill_before = rx_fill;
		n = frame_errs;
		send_frame(byte_t'($urandom()), 1'b0);
		repeat (2 * CLKS_PER_BIT) @(negedge clk);
		check_value("o_frame_err pulses", frame_errs - n, 1);
		check_value("o_rx_fill", 32'(rx_fill), 32'(fill_before));
		send_frame(byte_t'($urandom()), 1'b1);
		read_byte();
		check_value("bytes left in model", model_q.size(), 0);
		check_value("o_rx_empty", 32'(rx_empty), 1);

		$display("Checks: %0d, errors: %0d, timeouts: %0d", checks, errors, timeouts);
		if (errors == 0 && timeouts == 0)
			$display(">>> PASS");
		else
			$display(">>> FAIL");
		$finish;
	end

endmodule

//--- src.f
design/uart_pkg.sv
design/fifo_if.sv
design/sfifo.sv
design/uart_tx.sv
design/uart_rx.sv
design/uart_fifo_top.sv
testbench/tb_uart_fifo.sv

//--- Makefile
# Verilator build and run of the buffered UART link testbench

VERILATOR = verilator
VFLAGS    = --binary --timing --assert --timescale 1ns/1ps -Wno-fatal
TOP       = tb_uart_fifo
FILELIST  = src.f
BUILD_DIR = obj_dir
LOG       = sim.log
FAIL_MSG  = >>> FAIL

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the testbench, check the log"
	@echo "  clean  remove the build directory and the log"
	@echo "  help   list these targets"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)
	./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1; status=$$?; cat $(LOG); exit $$status
	@if grep -qF '$(FAIL_MSG)' $(LOG); then echo "Simulation failed"; exit 1; fi
	@echo "Simulation passed"

clean:
	rm -rf $(BUILD_DIR) $(LOG)
